// ==== cache.sv ====
/* Write-back cache */

`timescale 1ns/10ps

module cache #(
    parameter int ASSOCIATIVITY = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             cpu_cyc,
    input  logic             cpu_stb,
    input  logic             cpu_we,
    input  cache_pkg::addr_t cpu_adr,
    input  cache_pkg::bsel_t cpu_sel,
    input  cache_pkg::line_t cpu_dat_m,
    output cache_pkg::line_t cpu_dat_s,
    output logic             cpu_ack,
    output logic             mem_cyc,
    output logic             mem_stb,
    output logic             mem_we,
    output cache_pkg::addr_t mem_adr,
    output cache_pkg::bsel_t mem_sel,
    output cache_pkg::line_t mem_dat_m,
    input  cache_pkg::line_t mem_dat_s,
    input  logic             mem_ack
);

    logic [$clog2(ASSOCIATIVITY)-1:0] way_sel;
    logic [$clog2(ASSOCIATIVITY)-1:0] lru;
    logic [ASSOCIATIVITY-1:0] hit;
    logic data_src_sel;
    logic tag_bypass_sel;
    logic load;
    logic load_lru;
    logic dirty;

    assign mem_sel = '1;  // Memory moves whole lines.

    cache_datapath #(
        .ASSOCIATIVITY (ASSOCIATIVITY)
    ) u_datapath (
        .clk            (clk),
        .reset          (reset),
        .way_sel        (way_sel),
        .data_src_sel   (data_src_sel),
        .tag_bypass_sel (tag_bypass_sel),
        .load           (load),
        .load_lru       (load_lru),
        .cpu_adr        (cpu_adr),
        .cpu_sel        (cpu_sel),
        .cpu_dat_m      (cpu_dat_m),
        .mem_dat_s      (mem_dat_s),
        .hit            (hit),
        .dirty          (dirty),
        .lru            (lru),
        .cpu_dat_s      (cpu_dat_s),
        .mem_adr        (mem_adr),
        .mem_dat_m      (mem_dat_m)
    );

    cache_control #(
        .ASSOCIATIVITY (ASSOCIATIVITY)
    ) u_control (
        .clk            (clk),
        .reset          (reset),
        .cpu_stb        (cpu_stb),
        .cpu_cyc        (cpu_cyc),
        .cpu_we         (cpu_we),
        .hit            (hit),
        .dirty          (dirty),
        .lru            (lru),
        .mem_ack        (mem_ack),
        .cpu_ack        (cpu_ack),
        .mem_cyc        (mem_cyc),
        .mem_stb        (mem_stb),
        .mem_we         (mem_we),
        .way_sel        (way_sel),
        .data_src_sel   (data_src_sel),
        .tag_bypass_sel (tag_bypass_sel),
        .load           (load),
        .load_lru       (load_lru)
    );

endmodule

// ==== cache_control.sv ====
/* Cache controller */

`timescale 1ns/10ps

module cache_control #(
    parameter int ASSOCIATIVITY = 2
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             cpu_stb,
    input  logic                             cpu_cyc,
    input  logic                             cpu_we,
    input  logic [ASSOCIATIVITY-1:0]         hit,
    input  logic                             dirty,
    input  logic [$clog2(ASSOCIATIVITY)-1:0] lru,
    input  logic                             mem_ack,
    output logic                             cpu_ack,
    output logic                             mem_cyc,
    output logic                             mem_stb,
    output logic                             mem_we,
    output logic [$clog2(ASSOCIATIVITY)-1:0] way_sel,
    output logic                             data_src_sel,
    output logic                             tag_bypass_sel,
    output logic                             load,
    output logic                             load_lru
);

    localparam int WAY_W = $clog2(ASSOCIATIVITY);

    cache_pkg::ctrl_state_t state;
    cache_pkg::ctrl_state_t next_state;
    logic [WAY_W-1:0] hit_way;

    // Encode the hitting way.
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < ASSOCIATIVITY; w++) begin
            if (hit[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state     = state;
        cpu_ack        = 1'b0;
        mem_cyc        = 1'b0;
        mem_stb        = 1'b0;
        mem_we         = 1'b0;
        way_sel        = lru;  // Victim unless a way hits.
        data_src_sel   = cache_pkg::SRC_CPU;
        tag_bypass_sel = 1'b0;
        load           = 1'b0;
        load_lru       = 1'b0;
        case (state)
            cache_pkg::idle: begin
                if (cpu_cyc && cpu_stb) next_state = cache_pkg::compare;
            end
            cache_pkg::compare: begin
                if (|hit) begin
                    way_sel    = hit_way;
                    load       = cpu_we;  // Merge write data.
                    load_lru   = 1'b1;
                    cpu_ack    = 1'b1;
                    next_state = cache_pkg::idle;
                end else if (dirty) begin
                    next_state = cache_pkg::write_back;
                end else begin
                    next_state = cache_pkg::fill;
                end
            end
            cache_pkg::write_back: begin
                mem_cyc = 1'b1;
                mem_stb = 1'b1;
                mem_we  = 1'b1;
                if (mem_ack) next_state = cache_pkg::fill;
            end
            cache_pkg::fill: begin
                mem_cyc        = 1'b1;
                mem_stb        = 1'b1;
                tag_bypass_sel = 1'b1;
                data_src_sel   = cache_pkg::SRC_MEM;
                load           = mem_ack;  // Line is only valid with ack.
                if (mem_ack) next_state = cache_pkg::compare;
            end
            default: next_state = cache_pkg::idle;
        endcase
    end

endmodule

// ==== cache_datapath.sv ====
/* Cache datapath */

`timescale 1ns/10ps

module cache_datapath #(
    parameter int ASSOCIATIVITY = 2
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [$clog2(ASSOCIATIVITY)-1:0] way_sel,
    input  logic                             data_src_sel,
    input  logic                             tag_bypass_sel,
    input  logic                             load,
    input  logic                             load_lru,
    input  cache_pkg::addr_t                 cpu_adr,
    input  cache_pkg::bsel_t                 cpu_sel,
    input  cache_pkg::line_t                 cpu_dat_m,
    input  cache_pkg::line_t                 mem_dat_s,
    output logic [ASSOCIATIVITY-1:0]         hit,
    output logic                             dirty,
    output logic [$clog2(ASSOCIATIVITY)-1:0] lru,
    output cache_pkg::line_t                 cpu_dat_s,
    output cache_pkg::addr_t                 mem_adr,
    output cache_pkg::line_t                 mem_dat_m
);

    cache_pkg::tag_t   req_tag;
    cache_pkg::index_t index;
    cache_pkg::line_t  wr_data;
    cache_pkg::bsel_t  wr_sel;
    cache_pkg::tag_t   addr_tag;
    logic [ASSOCIATIVITY-1:0] way_load;
    logic [ASSOCIATIVITY-1:0] way_dirty;
    cache_pkg::line_t way_data [ASSOCIATIVITY];
    cache_pkg::tag_t  way_tag  [ASSOCIATIVITY];

    assign {req_tag, index} = cpu_adr;

    //////////////////////////////
    // Write side.
    //////////////////////////////
    assign wr_data  = (data_src_sel == cache_pkg::SRC_MEM) ? mem_dat_s : cpu_dat_m;
    assign wr_sel   = (data_src_sel == cache_pkg::SRC_MEM) ? '1 : cpu_sel;  // Fill is whole line.
    assign way_load = {{(ASSOCIATIVITY-1){1'b0}}, load} << way_sel;

    for (genvar w = 0; w < ASSOCIATIVITY; w++) begin : g_way
        cache_way u_way (
            .clk       (clk),
            .reset     (reset),
            .load      (way_load[w]),
            .load_type (data_src_sel),
            .byte_sel  (wr_sel),
            .tag_in    (req_tag),
            .index_in  (index),
            .data_in   (wr_data),
            .data_out  (way_data[w]),
            .tag_out   (way_tag[w]),
            .dirty_out (way_dirty[w]),
            .hit_out   (hit[w])
        );
    end

    cache_lru #(
        .ASSOCIATIVITY (ASSOCIATIVITY)
    ) u_lru (
        .clk      (clk),
        .reset    (reset),
        .mru_in   (way_sel),
        .index_in (index),
        .load_in  (load_lru),
        .lru_out  (lru)
    );

    //////////////////////////////
    // Read side.
    //////////////////////////////
    assign cpu_dat_s = way_data[way_sel];
    assign mem_dat_m = way_data[way_sel];  // Victim line on write-back.
    assign dirty     = way_dirty[lru];

    // Stored tag for write-back, request tag for fill.
    assign addr_tag = tag_bypass_sel ? req_tag : way_tag[way_sel];
    assign mem_adr  = {addr_tag, index};

endmodule

// ==== cache_lru.sv ====
/* Pseudo-LRU record */

`timescale 1ns/10ps

module cache_lru #(
    parameter int ASSOCIATIVITY = 2
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [$clog2(ASSOCIATIVITY)-1:0] mru_in,
    input  cache_pkg::index_t                index_in,
    input  logic                             load_in,
    output logic [$clog2(ASSOCIATIVITY)-1:0] lru_out
);

    localparam int LEVELS = $clog2(ASSOCIATIVITY);

    // One tree per set. Each node bit points toward the older half.
    logic [cache_pkg::NUM_LINES-1:0][ASSOCIATIVITY-2:0] tree;
    logic [ASSOCIATIVITY-2:0] tree_next;

    // Follow the node bits down to the victim way.
    always_comb begin
        int node;
        node = 0;
        for (int l = 0; l < LEVELS; l++) begin
            lru_out[LEVELS-1-l] = tree[index_in][node];
            node = 2 * node + 1 + int'(tree[index_in][node]);
        end
    end

    // Point every node on the path away from the used way.
    always_comb begin
        int node;
        tree_next = tree[index_in];
        node = 0;
        for (int l = 0; l < LEVELS; l++) begin
            tree_next[node] = ~mru_in[LEVELS-1-l];
            node = 2 * node + 1 + int'(mru_in[LEVELS-1-l]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tree <= '0;
        end else if (load_in) begin
            tree[index_in] <= tree_next;
        end
    end

endmodule

// ==== cache_pkg.sv ====
/* Cache shared definitions */

package cache_pkg;

    //////////////////////////////
    // Bus and address widths.
    //////////////////////////////
    parameter int WIDTH     = 128;              // One line per transfer.
    parameter int SEL_W     = WIDTH / 8;
    parameter int ADDR_W    = 12;               // Line address.
    parameter int NUM_LINES = 8;                // Sets per way.
    parameter int INDEX_W   = $clog2(NUM_LINES);
    parameter int TAG_W     = ADDR_W - INDEX_W;

    typedef logic [WIDTH-1:0]   line_t;
    typedef logic [SEL_W-1:0]   bsel_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    // Write source of a way.
    parameter logic SRC_CPU = 1'b0;
    parameter logic SRC_MEM = 1'b1;

    //////////////////////////////
    // Controller states.
    //////////////////////////////
    typedef enum logic [1:0] {
        idle,
        compare,
        write_back,
        fill
    } ctrl_state_t;

endpackage

// ==== cache_top.f ====
cache_pkg.sv
cache_way.sv
cache_lru.sv
cache_datapath.sv
cache_control.sv
cache.sv
mem_arbiter.sv
cache_top.sv
cache_top_assert.sv
tb_cache_top.sv

// ==== cache_top.sv ====
/* Dual-port cache top */

`timescale 1ns/10ps

module cache_top #(
    parameter int ASSOCIATIVITY = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             cpu_0_cyc,
    input  logic             cpu_0_stb,
    input  logic             cpu_0_we,
    input  cache_pkg::addr_t cpu_0_adr,
    input  cache_pkg::bsel_t cpu_0_sel,
    input  cache_pkg::line_t cpu_0_dat_m,
    output cache_pkg::line_t cpu_0_dat_s,
    output logic             cpu_0_ack,
    input  logic             cpu_1_cyc,
    input  logic             cpu_1_stb,
    input  logic             cpu_1_we,
    input  cache_pkg::addr_t cpu_1_adr,
    input  cache_pkg::bsel_t cpu_1_sel,
    input  cache_pkg::line_t cpu_1_dat_m,
    output cache_pkg::line_t cpu_1_dat_s,
    output logic             cpu_1_ack,
    output logic             mem_cyc,
    output logic             mem_stb,
    output logic             mem_we,
    output cache_pkg::addr_t mem_adr,
    output cache_pkg::bsel_t mem_sel,
    output cache_pkg::line_t mem_dat_m,
    input  cache_pkg::line_t mem_dat_s,
    input  logic             mem_ack
);

    // Per-cache memory side.
    logic             c0_cyc, c0_stb, c0_we, c0_ack;
    logic             c1_cyc, c1_stb, c1_we, c1_ack;
    cache_pkg::addr_t c0_adr, c1_adr;
    cache_pkg::bsel_t c0_sel, c1_sel;
    cache_pkg::line_t c0_dat_m, c1_dat_m;
    cache_pkg::line_t c0_dat_s, c1_dat_s;

    cache #(
        .ASSOCIATIVITY (ASSOCIATIVITY)
    ) u_cache0 (
        .clk       (clk),
        .reset     (reset),
        .cpu_cyc   (cpu_0_cyc),
        .cpu_stb   (cpu_0_stb),
        .cpu_we    (cpu_0_we),
        .cpu_adr   (cpu_0_adr),
        .cpu_sel   (cpu_0_sel),
        .cpu_dat_m (cpu_0_dat_m),
        .cpu_dat_s (cpu_0_dat_s),
        .cpu_ack   (cpu_0_ack),
        .mem_cyc   (c0_cyc),
        .mem_stb   (c0_stb),
        .mem_we    (c0_we),
        .mem_adr   (c0_adr),
        .mem_sel   (c0_sel),
        .mem_dat_m (c0_dat_m),
        .mem_dat_s (c0_dat_s),
        .mem_ack   (c0_ack)
    );

    cache #(
        .ASSOCIATIVITY (ASSOCIATIVITY)
    ) u_cache1 (
        .clk       (clk),
        .reset     (reset),
        .cpu_cyc   (cpu_1_cyc),
        .cpu_stb   (cpu_1_stb),
        .cpu_we    (cpu_1_we),
        .cpu_adr   (cpu_1_adr),
        .cpu_sel   (cpu_1_sel),
        .cpu_dat_m (cpu_1_dat_m),
        .cpu_dat_s (cpu_1_dat_s),
        .cpu_ack   (cpu_1_ack),
        .mem_cyc   (c1_cyc),
        .mem_stb   (c1_stb),
        .mem_we    (c1_we),
        .mem_adr   (c1_adr),
        .mem_sel   (c1_sel),
        .mem_dat_m (c1_dat_m),
        .mem_dat_s (c1_dat_s),
        .mem_ack   (c1_ack)
    );

    mem_arbiter u_arbiter (
        .clk       (clk),
        .reset     (reset),
        .cyc0      (c0_cyc),
        .stb0      (c0_stb),
        .we0       (c0_we),
        .adr0      (c0_adr),
        .sel0      (c0_sel),
        .dat_m0    (c0_dat_m),
        .cyc1      (c1_cyc),
        .stb1      (c1_stb),
        .we1       (c1_we),
        .adr1      (c1_adr),
        .sel1      (c1_sel),
        .dat_m1    (c1_dat_m),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_sel   (mem_sel),
        .mem_dat_m (mem_dat_m),
        .mem_ack   (mem_ack),
        .mem_dat_s (mem_dat_s),
        .ack0      (c0_ack),
        .ack1      (c1_ack),
        .dat_s0    (c0_dat_s),
        .dat_s1    (c1_dat_s)
    );

endmodule

// ==== cache_top_assert.sv ====
/* Cache bus protocol checks */

`timescale 1ns/10ps

module cache_top_assert (
    input logic             clk,
    input logic             reset,
    input logic             cpu_0_stb,
    input logic             cpu_0_ack,
    input logic             cpu_1_stb,
    input logic             cpu_1_ack,
    input logic             mem_cyc,
    input logic             mem_stb,
    input logic             mem_ack,
    input cache_pkg::addr_t mem_adr,
    input cache_pkg::bsel_t mem_sel,
    input logic [1:0]       gnt
);

    int fail_count = 0;  // Read by the testbench.

    //////////////////////////////
    // CPU side.
    //////////////////////////////
    ack0_with_stb: assert property (@(posedge clk) disable iff (reset)
        cpu_0_ack |-> cpu_0_stb)
        else begin
            $error("cpu_0_ack came without cpu_0_stb");
            fail_count++;
        end

    ack1_with_stb: assert property (@(posedge clk) disable iff (reset)
        cpu_1_ack |-> cpu_1_stb)
        else begin
            $error("cpu_1_ack came without cpu_1_stb");
            fail_count++;
        end

    ack0_pulse: assert property (@(posedge clk) disable iff (reset)
        cpu_0_ack |=> !cpu_0_ack)
        else begin
            $error("cpu_0_ack stayed high for two cycles");
            fail_count++;
        end

    ack1_pulse: assert property (@(posedge clk) disable iff (reset)
        cpu_1_ack |=> !cpu_1_ack)
        else begin
            $error("cpu_1_ack stayed high for two cycles");
            fail_count++;
        end

    //////////////////////////////
    // Memory side.
    //////////////////////////////
    mem_hold: assert property (@(posedge clk) disable iff (reset)
        mem_stb && !mem_ack |=> mem_stb && $stable(mem_adr))
        else begin
            $error("memory request changed before mem_ack");
            fail_count++;
        end

    mem_whole_line: assert property (@(posedge clk) disable iff (reset)
        mem_stb |-> mem_cyc && (mem_sel == '1))
        else begin
            $error("memory strobe came without cyc or with a partial byte select");
            fail_count++;
        end

    one_grant: assert property (@(posedge clk) disable iff (reset)
        $onehot0(gnt))
        else begin
            $error("both caches hold a bus grant");
            fail_count++;
        end

endmodule

bind cache_top cache_top_assert u_protocol_assert (
    .clk       (clk),
    .reset     (reset),
    .cpu_0_stb (cpu_0_stb),
    .cpu_0_ack (cpu_0_ack),
    .cpu_1_stb (cpu_1_stb),
    .cpu_1_ack (cpu_1_ack),
    .mem_cyc   (mem_cyc),
    .mem_stb   (mem_stb),
    .mem_ack   (mem_ack),
    .mem_adr   (mem_adr),
    .mem_sel   (mem_sel),
    .gnt       (u_arbiter.gnt)
);

// ==== cache_way.sv ====
/* Cache way storage */

`timescale 1ns/10ps

module cache_way (
    input  logic              clk,
    input  logic              reset,
    input  logic              load,
    input  logic              load_type,  // Memory fill when high.
    input  cache_pkg::bsel_t  byte_sel,
    input  cache_pkg::tag_t   tag_in,
    input  cache_pkg::index_t index_in,
    input  cache_pkg::line_t  data_in,
    output cache_pkg::line_t  data_out,
    output cache_pkg::tag_t   tag_out,
    output logic              dirty_out,
    output logic              hit_out
);

    cache_pkg::line_t data_mem [cache_pkg::NUM_LINES];
    cache_pkg::tag_t  tag_mem  [cache_pkg::NUM_LINES];
    logic [cache_pkg::NUM_LINES-1:0] valid;
    logic [cache_pkg::NUM_LINES-1:0] dirty;
    cache_pkg::line_t merged;

    // Byte merge of new data over the stored line.
    always_comb begin
        for (int b = 0; b < $bits(cache_pkg::bsel_t); b++) begin
            merged[8*b +: 8] = byte_sel[b] ? data_in[8*b +: 8] : data_mem[index_in][8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_mem[index_in] <= merged;
        end
        if (load && load_type == cache_pkg::SRC_MEM) begin
            tag_mem[index_in] <= tag_in;  // CPU writes keep the tag.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
        end else if (load) begin
            if (load_type == cache_pkg::SRC_MEM) begin
                valid[index_in] <= 1'b1;
                dirty[index_in] <= 1'b0;  // Fresh from memory.
            end else begin
                dirty[index_in] <= 1'b1;
            end
        end
    end

    assign data_out  = data_mem[index_in];
    assign tag_out   = tag_mem[index_in];
    assign dirty_out = dirty[index_in];
    assign hit_out   = valid[index_in] && (tag_mem[index_in] == tag_in);

endmodule

// ==== mem_arbiter.sv ====
/* Memory bus arbiter */

`timescale 1ns/10ps

module mem_arbiter (
    input  logic             clk,
    input  logic             reset,
    input  logic             cyc0,
    input  logic             stb0,
    input  logic             we0,
    input  cache_pkg::addr_t adr0,
    input  cache_pkg::bsel_t sel0,
    input  cache_pkg::line_t dat_m0,
    input  logic             cyc1,
    input  logic             stb1,
    input  logic             we1,
    input  cache_pkg::addr_t adr1,
    input  cache_pkg::bsel_t sel1,
    input  cache_pkg::line_t dat_m1,
    output logic             mem_cyc,
    output logic             mem_stb,
    output logic             mem_we,
    output cache_pkg::addr_t mem_adr,
    output cache_pkg::bsel_t mem_sel,
    output cache_pkg::line_t mem_dat_m,
    input  logic             mem_ack,
    input  cache_pkg::line_t mem_dat_s,
    output logic             ack0,
    output logic             ack1,
    output cache_pkg::line_t dat_s0,
    output cache_pkg::line_t dat_s1
);

    logic [1:0] gnt;  // One-hot owner, zero when idle.
    logic       prio;  // Port favoured at the next arbitration.
    logic       owner_busy;

    assign owner_busy = (gnt[0] && cyc0) || (gnt[1] && cyc1);

    // Re-arbitrate only once the owner drops cyc.
    always_ff @(posedge clk) begin
        if (reset) begin
            gnt  <= 2'b00;
            prio <= 1'b0;
        end else if (!owner_busy) begin
            if (cyc0 && (!cyc1 || !prio)) begin
                gnt  <= 2'b01;
                prio <= 1'b1;
            end else if (cyc1) begin
                gnt  <= 2'b10;
                prio <= 1'b0;
            end else begin
                gnt  <= 2'b00;
            end
        end
    end

    //////////////////////////////
    // Bus mux.
    //////////////////////////////
    assign mem_cyc   = (gnt[0] && cyc0) || (gnt[1] && cyc1);
    assign mem_stb   = (gnt[0] && stb0) || (gnt[1] && stb1);
    assign mem_we    = gnt[1] ? we1 : we0;
    assign mem_adr   = gnt[1] ? adr1 : adr0;
    assign mem_sel   = gnt[1] ? sel1 : sel0;
    assign mem_dat_m = gnt[1] ? dat_m1 : dat_m0;

    assign ack0   = mem_ack && gnt[0];  // Ack only to the owner.
    assign ack1   = mem_ack && gnt[1];
    assign dat_s0 = mem_dat_s;
    assign dat_s1 = mem_dat_s;

endmodule

// ==== tb_cache_top.sv ====
/* Dual cache testbench */

`timescale 1ns/10ps

module tb_cache_top;

    localparam int CLK_PERIOD   = 10;
    localparam int RAND_OPS     = 40;  // Per port.
    localparam int NUM_REQUESTS = 17 + 2 * RAND_OPS;
    localparam int LIMIT_CYCLES = NUM_REQUESTS * 40 + 10;
    localparam int MEM_LINES    = 1 << cache_pkg::ADDR_W;

    logic             clk;
    logic             reset;
    logic             cpu_0_cyc, cpu_0_stb, cpu_0_we, cpu_0_ack;
    logic             cpu_1_cyc, cpu_1_stb, cpu_1_we, cpu_1_ack;
    cache_pkg::addr_t cpu_0_adr, cpu_1_adr;
    cache_pkg::bsel_t cpu_0_sel, cpu_1_sel;
    cache_pkg::line_t cpu_0_dat_m, cpu_1_dat_m;
    cache_pkg::line_t cpu_0_dat_s, cpu_1_dat_s;
    logic             mem_cyc, mem_stb, mem_we, mem_ack;
    cache_pkg::addr_t mem_adr;
    cache_pkg::bsel_t mem_sel;
    cache_pkg::line_t mem_dat_m, mem_dat_s;

    cache_pkg::line_t mem    [MEM_LINES];
    cache_pkg::line_t shadow [MEM_LINES];  // Expected CPU view.
    logic [1:0]       mem_wait;
    logic             mem_busy;
    cache_pkg::addr_t wr_adr_q [$];
    cache_pkg::line_t wr_dat_q [$];
    logic             owner_q  [$];        // Address bit 11 names the port.
    integer           seed;
    int               checks;
    int               errors;
    int               last_errors;

    cache_top #(
        .ASSOCIATIVITY (2)
    ) u_dut (
        .clk         (clk),
        .reset       (reset),
        .cpu_0_cyc   (cpu_0_cyc),
        .cpu_0_stb   (cpu_0_stb),
        .cpu_0_we    (cpu_0_we),
        .cpu_0_adr   (cpu_0_adr),
        .cpu_0_sel   (cpu_0_sel),
        .cpu_0_dat_m (cpu_0_dat_m),
        .cpu_0_dat_s (cpu_0_dat_s),
        .cpu_0_ack   (cpu_0_ack),
        .cpu_1_cyc   (cpu_1_cyc),
        .cpu_1_stb   (cpu_1_stb),
        .cpu_1_we    (cpu_1_we),
        .cpu_1_adr   (cpu_1_adr),
        .cpu_1_sel   (cpu_1_sel),
        .cpu_1_dat_m (cpu_1_dat_m),
        .cpu_1_dat_s (cpu_1_dat_s),
        .cpu_1_ack   (cpu_1_ack),
        .mem_cyc     (mem_cyc),
        .mem_stb     (mem_stb),
        .mem_we      (mem_we),
        .mem_adr     (mem_adr),
        .mem_sel     (mem_sel),
        .mem_dat_m   (mem_dat_m),
        .mem_dat_s   (mem_dat_s),
        .mem_ack     (mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // Memory model.
    //////////////////////////////
    always @(posedge clk) begin
        if (reset) begin
            mem_ack  <= 1'b0;
            mem_busy <= 1'b0;
            mem_wait <= 2'd0;
        end else if (mem_ack) begin
            mem_ack <= 1'b0;  // One-cycle pulse.
        end else if (mem_busy && mem_wait != 2'd0) begin
            mem_wait <= mem_wait - 2'd1;
        end else if (mem_busy) begin
            mem_busy <= 1'b0;
            mem_ack  <= 1'b1;
            owner_q.push_back(mem_adr[11]);
            if (mem_we) begin
                mem[mem_adr] <= mem_dat_m;
                wr_adr_q.push_back(mem_adr);
                wr_dat_q.push_back(mem_dat_m);
            end else begin
                mem_dat_s <= mem[mem_adr];
            end
        end else if (mem_stb) begin
            mem_busy <= 1'b1;
            mem_wait <= 2'($random(seed));  // Ack 1 to 4 cycles on.
        end
    end

    function automatic int total_errors();
        return errors + u_dut.u_protocol_assert.fail_count;
    endfunction

    task automatic drive_port(input int port, input logic active, input logic we,
                              input cache_pkg::addr_t adr, input cache_pkg::bsel_t sel,
                              input cache_pkg::line_t dat);
        if (port == 0) begin
            cpu_0_cyc   <= active;
            cpu_0_stb   <= active;
            cpu_0_we    <= we;
            cpu_0_adr   <= adr;
            cpu_0_sel   <= sel;
            cpu_0_dat_m <= dat;
        end else begin
            cpu_1_cyc   <= active;
            cpu_1_stb   <= active;
            cpu_1_we    <= we;
            cpu_1_adr   <= adr;
            cpu_1_sel   <= sel;
            cpu_1_dat_m <= dat;
        end
    endtask

    // One request, held until ack. Reads are checked against the shadow.
    task automatic cpu_access(input int port, input logic we, input cache_pkg::addr_t adr,
                              input cache_pkg::bsel_t sel, input cache_pkg::line_t dat,
                              output int cycles);
        cache_pkg::line_t got;
        logic             ack;
        cycles = 0;
        ack    = 1'b0;
        @(posedge clk);
        drive_port(port, 1'b1, we, adr, sel, dat);
        while (!ack) begin
            @(negedge clk);
            cycles++;
            ack = (port == 0) ? cpu_0_ack : cpu_1_ack;
            got = (port == 0) ? cpu_0_dat_s : cpu_1_dat_s;
        end
        if (we) begin
            for (int b = 0; b < $bits(cache_pkg::bsel_t); b++) begin
                if (sel[b]) shadow[adr][8*b +: 8] = dat[8*b +: 8];
            end
        end else begin
            checks++;
            assert (got === shadow[adr]) else begin
                $display("error: time %0t, cpu_%0d_dat_s expected %h, actual %h",
                         $time, port, shadow[adr], got);
                errors++;
            end
        end
        @(posedge clk);
        drive_port(port, 1'b0, 1'b0, adr, sel, dat);
    endtask

    task automatic check_latency(input string name, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            $display("error: time %0t, %s latency expected %0d, actual %0d",
                     $time, name, expected, got);
            errors++;
        end
    endtask

    task automatic check_miss(input string what, input int cycles);
        checks++;
        assert (cycles > 2) else begin
            $display("%s was served as a hit where a miss was due", what);
            errors++;
        end
    endtask

    // Looks for a memory write of the line with its merged data.
    task automatic check_write_back(input cache_pkg::addr_t adr);
        bit found;
        found = 1'b0;
        foreach (wr_adr_q[i]) begin
            if (wr_adr_q[i] == adr && wr_dat_q[i] === shadow[adr]) found = 1'b1;
        end
        checks++;
        assert (found) else begin
            $display("no memory write of line %h with its merged data was seen", adr);
            errors++;
        end
    endtask

    task automatic check_alternation(input int expected);
        checks++;
        assert (owner_q.size() == expected) else begin
            $display("expected %0d memory transactions, saw %0d", expected, owner_q.size());
            errors++;
        end
        for (int i = 1; i < owner_q.size(); i++) begin
            assert (owner_q[i] != owner_q[i-1]) else begin
                $display("memory transactions %0d and %0d both came from cache %0d",
                         i - 1, i, owner_q[i]);
                errors++;
            end
        end
    endtask

    task automatic random_traffic(input int port);
        cache_pkg::tag_t   tag;
        cache_pkg::index_t idx;
        cache_pkg::bsel_t  sel;
        cache_pkg::line_t  dat;
        logic              we;
        int                cycles;
        repeat (RAND_OPS) begin
            tag = {port[0], 6'd0, 2'($random(seed))};  // Four tags per set.
            idx = cache_pkg::index_t'($random(seed));
            we  = 1'($random(seed));
            sel = cache_pkg::bsel_t'($random(seed));
            dat = {$random(seed), $random(seed), $random(seed), $random(seed)};
            cpu_access(port, we, {tag, idx}, sel, dat, cycles);
        end
    endtask

    task automatic report_test(input int num, input string name);
        int count;
        count = total_errors();
        $display("test %0d, %s: %0d errors", num, name, count - last_errors);
        last_errors = count;
    endtask

    //////////////////////////////
    // Test sequence.
    //////////////////////////////
    initial begin
        int               cycles0;
        int               cycles1;
        cache_pkg::line_t dat;
        seed        = 72019;
        checks      = 0;
        errors      = 0;
        last_errors = 0;
        reset       = 1'b1;
        mem_ack     = 1'b0;
        mem_dat_s   = '0;
        drive_port(0, 1'b0, 1'b0, '0, '0, '0);
        drive_port(1, 1'b0, 1'b0, '0, '0, '0);
        foreach (mem[i]) begin
            mem[i]    = {$random(seed), $random(seed), $random(seed), $random(seed)};
            shadow[i] = mem[i];
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        cpu_access(0, 1'b0, {9'h011, 3'd1}, '1, '0, cycles0);
        check_miss("first read of line 089", cycles0);
        cpu_access(0, 1'b0, {9'h011, 3'd1}, '1, '0, cycles0);
        check_latency("cpu_0_ack", cycles0, 2);
        report_test(1, "read miss then hit");

        dat = {$random(seed), $random(seed), $random(seed), $random(seed)};
        cpu_access(0, 1'b1, {9'h011, 3'd1}, 16'h0ff0, dat, cycles0);
        cpu_access(0, 1'b0, {9'h011, 3'd1}, '1, '0, cycles0);
        report_test(2, "partial write then read");

        dat = {$random(seed), $random(seed), $random(seed), $random(seed)};
        cpu_access(0, 1'b1, {9'h021, 3'd2}, 16'hff00, dat, cycles0);
        cpu_access(0, 1'b0, {9'h022, 3'd2}, '1, '0, cycles0);
        cpu_access(0, 1'b0, {9'h023, 3'd2}, '1, '0, cycles0);  // Evicts the dirty line.
        check_write_back({9'h021, 3'd2});
        report_test(3, "dirty eviction");

        cpu_access(0, 1'b0, {9'h031, 3'd3}, '1, '0, cycles0);
        cpu_access(0, 1'b0, {9'h032, 3'd3}, '1, '0, cycles0);
        cpu_access(0, 1'b0, {9'h031, 3'd3}, '1, '0, cycles0);
        check_latency("cpu_0_ack", cycles0, 2);
        cpu_access(0, 1'b0, {9'h033, 3'd3}, '1, '0, cycles0);
        cpu_access(0, 1'b0, {9'h031, 3'd3}, '1, '0, cycles0);
        check_latency("cpu_0_ack", cycles0, 2);
        cpu_access(0, 1'b0, {9'h032, 3'd3}, '1, '0, cycles0);
        check_miss("read of the evicted line 193", cycles0);
        report_test(4, "LRU replacement");

        owner_q.delete();
        fork
            begin
                cpu_access(0, 1'b0, {9'h071, 3'd7}, '1, '0, cycles0);
                cpu_access(0, 1'b0, {9'h072, 3'd7}, '1, '0, cycles0);
            end
            begin
                cpu_access(1, 1'b0, {9'h171, 3'd7}, '1, '0, cycles1);
                cpu_access(1, 1'b0, {9'h172, 3'd7}, '1, '0, cycles1);
            end
        join
        check_miss("read of line 397 on port 0", cycles0);
        check_miss("read of line b97 on port 1", cycles1);
        check_alternation(4);
        report_test(5, "concurrent misses");

        fork
            random_traffic(0);
            random_traffic(1);
        join
        report_test(6, "random traffic");

        repeat (5) @(posedge clk);
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, u_dut.u_protocol_assert.fail_count);
        if (total_errors() == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("watchdog timeout, the run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule
